//--- uart_pkg.sv
package uart_pkg;

    typedef enum logic [1:0] {
        tx_idle  = 2'd0,
        tx_start = 2'd1,
        tx_data  = 2'd2,
        tx_stop  = 2'd3
    } tx_state_t;

    typedef enum logic [1:0] {
        rx_idle  = 2'd0,
        rx_start = 2'd1,
        rx_data  = 2'd2,
        rx_stop  = 2'd3
    } rx_state_t;

    // Positions of the flags inside the 4-bit status word.
    localparam int stat_tx_active = 0;
    localparam int stat_rx_active = 1;
    localparam int stat_overrun   = 2;
    localparam int stat_frame_err = 3;

endpackage

//--- stream_if.sv
`timescale 1ns/1ns

interface stream_if #(
    parameter int dw = 8
);
    logic [dw-1:0] data;
    logic          valid;
    logic          last;
    logic          ready;

    modport src (
        output data,
        output valid,
        output last,
        input  ready
    );

    modport snk (
        input  data,
        input  valid,
        input  last,
        output ready
    );

endinterface

//--- stream_fifo.sv
`timescale 1ns/1ns

module stream_fifo #(
    parameter int dw = 8,
    parameter int aw = 4
) (
    input  logic  clk,
    input  logic  rst,
    stream_if.snk wr,
    stream_if.src rd,
    output logic  empty
);
    localparam int depth = 2 ** aw;

    logic [dw-1:0] data_mem [depth];
    logic          last_mem [depth];
    logic [aw:0]   wr_ptr;
    logic [aw:0]   rd_ptr;
    logic [aw:0]   rd_ptr_next;
    logic          full;
    logic          wr_fire;
    logic          rd_fire;
    logic [dw-1:0] out_data;
    logic          out_last;
    logic          out_valid;

    // The extra pointer bit differs only when the buffer has wrapped.
    assign full = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign wr.ready = ~full;
    assign wr_fire = wr.valid & ~full;
    assign rd_fire = out_valid & rd.ready;
    assign rd_ptr_next = rd_ptr + {{aw{1'b0}}, rd_fire};

    assign rd.data = out_data;
    assign rd.last = out_last;
    assign rd.valid = out_valid;

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            data_mem[wr_ptr[aw-1:0]] <= wr.data;
            last_mem[wr_ptr[aw-1:0]] <= wr.last;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            rd_ptr <= rd_ptr_next;
        end
    end

    // The head entry stays in the memory until it is read, so the output
    // stage adds no capacity; a slot written this cycle shows up next cycle.
    always_ff @(posedge clk) begin
        out_data <= data_mem[rd_ptr_next[aw-1:0]];
        out_last <= last_mem[rd_ptr_next[aw-1:0]];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= (wr_ptr != rd_ptr_next); // Old write pointer on purpose.
        end
    end

endmodule

//--- uart_tx.sv
`timescale 1ns/1ns

module uart_tx import uart_pkg::*; #(
    parameter int dw = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] prescale,
    stream_if.snk       in_s,
    output logic        txd,
    output logic        busy
);
    localparam int bw = (dw > 1) ? $clog2(dw) : 1;

    tx_state_t     state;
    logic [18:0]   bit_len;
    logic [18:0]   cnt;
    logic [dw-1:0] shreg;
    logic [bw-1:0] bitn;

    assign bit_len = {prescale, 3'b000}; // Eight clocks per prescale step.
    assign in_s.ready = (state == tx_idle);
    assign busy = (state != tx_idle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= tx_idle;
            txd <= 1'b1;
            cnt <= '0;
            bitn <= '0;
        end else begin
            case (state)
                tx_idle: begin
                    txd <= 1'b1;
                    if (in_s.valid) begin
                        shreg <= in_s.data;
                        txd <= 1'b0; // Start bit.
                        cnt <= bit_len - 19'd1;
                        state <= tx_start;
                    end
                end
                tx_start: begin
                    if (cnt == '0) begin
                        txd <= shreg[0];
                        shreg <= shreg >> 1;
                        bitn <= bw'(dw - 1);
                        cnt <= bit_len - 19'd1;
                        state <= tx_data;
                    end else begin
                        cnt <= cnt - 19'd1;
                    end
                end
                tx_data: begin
                    if (cnt == '0) begin
                        cnt <= bit_len - 19'd1;
                        if (bitn == '0) begin
                            txd <= 1'b1; // Stop bit.
                            state <= tx_stop;
                        end else begin
                            txd <= shreg[0];
                            shreg <= shreg >> 1;
                            bitn <= bitn - 1'b1;
                        end
                    end else begin
                        cnt <= cnt - 19'd1;
                    end
                end
                tx_stop: begin
                    if (cnt == '0) begin
                        state <= tx_idle;
                    end else begin
                        cnt <= cnt - 19'd1;
                    end
                end
                default: state <= tx_idle;
            endcase
        end
    end

endmodule

//--- uart_rx.sv
`timescale 1ns/1ns

module uart_rx import uart_pkg::*; #(
    parameter int dw = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] prescale,
    input  logic        rxd,
    stream_if.src       out_s,
    output logic        busy,
    output logic        frame_ok,
    output logic        frame_err,
    output logic        overrun
);
    localparam int bw = (dw > 1) ? $clog2(dw) : 1;

    rx_state_t     state;
    logic [1:0]    rx_sync;
    logic          rxd_s;
    logic          rxd_prev;
    logic [18:0]   bit_len;
    logic [18:0]   half_len;
    logic [18:0]   cnt;
    logic [dw-1:0] shreg;
    logic [bw-1:0] bitn;
    logic [dw-1:0] out_data;
    logic          out_valid;

    assign bit_len = {prescale, 3'b000};
    assign half_len = {1'b0, prescale, 2'b00};
    assign rxd_s = rx_sync[1];

    assign out_s.data = out_data;
    assign out_s.valid = out_valid;
    assign out_s.last = 1'b1; // Every received byte is a packet of its own.
    assign busy = (state != rx_idle);

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_sync <= 2'b11;
            rxd_prev <= 1'b1;
        end else begin
            rx_sync <= {rx_sync[0], rxd};
            rxd_prev <= rxd_s;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= rx_idle;
            cnt <= '0;
            bitn <= '0;
            out_valid <= 1'b0;
            frame_ok <= 1'b0;
            frame_err <= 1'b0;
            overrun <= 1'b0;
        end else begin
            frame_ok <= 1'b0;
            frame_err <= 1'b0;
            overrun <= 1'b0;
            if (out_valid && out_s.ready) begin
                out_valid <= 1'b0;
            end
            case (state)
                rx_idle: begin
                    if (rxd_prev && !rxd_s) begin
                        cnt <= half_len - 19'd1; // Aim at the middle of the start bit.
                        state <= rx_start;
                    end
                end
                rx_start: begin
                    if (cnt == '0) begin
                        if (!rxd_s) begin
                            cnt <= bit_len - 19'd1;
                            bitn <= bw'(dw - 1);
                            state <= rx_data;
                        end else begin
                            state <= rx_idle; // A glitch, not a start bit.
                        end
                    end else begin
                        cnt <= cnt - 19'd1;
                    end
                end
                rx_data: begin
                    if (cnt == '0) begin
                        shreg <= {rxd_s, shreg[dw-1:1]}; // Least significant bit arrives first.
                        cnt <= bit_len - 19'd1;
                        if (bitn == '0) begin
                            state <= rx_stop;
                        end else begin
                            bitn <= bitn - 1'b1;
                        end
                    end else begin
                        cnt <= cnt - 19'd1;
                    end
                end
                rx_stop: begin
                    if (cnt == '0) begin
                        state <= rx_idle;
                        if (rxd_s) begin
                            frame_ok <= 1'b1;
                            if (out_valid && !out_s.ready) begin
                                overrun <= 1'b1; // Held byte wins, new one is lost.
                            end else begin
                                out_data <= shreg;
                                out_valid <= 1'b1;
                            end
                        end else begin
                            frame_err <= 1'b1;
                        end
                    end else begin
                        cnt <= cnt - 19'd1;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

endmodule

//--- uart_status.sv
`timescale 1ns/1ns

module uart_status import uart_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       tx_busy,
    input  logic       tx_empty,
    input  logic       rx_busy,
    input  logic       rx_empty,
    input  logic       frame_ok,
    input  logic       frame_err,
    input  logic       overrun,
    output logic [3:0] status
);

    always_ff @(posedge clk) begin
        if (rst) begin
            status <= '0;
        end else begin
            status[stat_tx_active] <= tx_busy | ~tx_empty;
            status[stat_rx_active] <= rx_busy | ~rx_empty;

            // Sticky until the receive FIFO has been drained.
            if (overrun) begin
                status[stat_overrun] <= 1'b1;
            end else if (rx_empty) begin
                status[stat_overrun] <= 1'b0;
            end

            if (frame_err) begin
                status[stat_frame_err] <= 1'b1;
            end else if (frame_ok) begin
                status[stat_frame_err] <= 1'b0; // The next clean frame clears it.
            end
        end
    end

endmodule

//--- uart_stream.sv
`timescale 1ns/1ns

module uart_stream #(
    parameter int dw    = 8,
    parameter int aw_tx = 4,
    parameter int aw_rx = 4
) (
    input  logic          clk,
    input  logic          rst,
    input  logic [15:0]   prescale,
    output logic [3:0]    status,

    input  logic [dw-1:0] utx_tdata,
    input  logic          utx_tvalid,
    input  logic          utx_tlast,
    output logic          utx_tready,

    output logic [dw-1:0] urx_tdata,
    output logic          urx_tvalid,
    output logic          urx_tlast,
    input  logic          urx_tready,

    output logic          txd,
    input  logic          rxd
);
    logic tx_busy;
    logic tx_empty;
    logic rx_busy;
    logic rx_empty;
    logic frame_ok;
    logic frame_err;
    logic overrun;

    stream_if #(.dw(dw)) utx ();
    stream_if #(.dw(dw)) tx_s ();
    stream_if #(.dw(dw)) rx_s ();
    stream_if #(.dw(dw)) urx ();

    assign utx.data = utx_tdata;
    assign utx.valid = utx_tvalid;
    assign utx.last = utx_tlast;
    assign utx_tready = utx.ready;

    assign urx_tdata = urx.data;
    assign urx_tvalid = urx.valid;
    assign urx_tlast = urx.last;
    assign urx.ready = urx_tready;

    stream_fifo #(.dw(dw), .aw(aw_tx)) tx_fifo_i (
        .clk   (clk),
        .rst   (rst),
        .wr    (utx.snk),
        .rd    (tx_s.src),
        .empty (tx_empty)
    );

    uart_tx #(.dw(dw)) uart_tx_i (
        .clk      (clk),
        .rst      (rst),
        .prescale (prescale),
        .in_s     (tx_s.snk),
        .txd      (txd),
        .busy     (tx_busy)
    );

    uart_rx #(.dw(dw)) uart_rx_i (
        .clk       (clk),
        .rst       (rst),
        .prescale  (prescale),
        .rxd       (rxd),
        .out_s     (rx_s.src),
        .busy      (rx_busy),
        .frame_ok  (frame_ok),
        .frame_err (frame_err),
        .overrun   (overrun)
    );

    stream_fifo #(.dw(dw), .aw(aw_rx)) rx_fifo_i (
        .clk   (clk),
        .rst   (rst),
        .wr    (rx_s.snk),
        .rd    (urx.src),
        .empty (rx_empty)
    );

    uart_status uart_status_i (
        .clk       (clk),
        .rst       (rst),
        .tx_busy   (tx_busy),
        .tx_empty  (tx_empty),
        .rx_busy   (rx_busy),
        .rx_empty  (rx_empty),
        .frame_ok  (frame_ok),
        .frame_err (frame_err),
        .overrun   (overrun),
        .status    (status)
    );

endmodule

//--- tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int period = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

endmodule

//--- uart_stream_tb.sv
`timescale 1ns/1ns

module uart_stream_tb import uart_pkg::*; ();
    localparam int aw_tx = 2;
    localparam int aw_rx = 2;
    localparam int tx_keep = 2 ** aw_tx + 1; // FIFO entries plus the byte in the serializer.
    localparam int rx_keep = 2 ** aw_rx + 1; // FIFO entries plus the byte held in uart_rx.
    localparam int max_steps = 64;
    localparam int ready_low = 0;
    localparam int ready_high = 1;
    localparam int ready_random = 2;
    localparam logic [3:0] tx_mask = 4'b0001 << stat_tx_active;
    localparam logic [3:0] busy_mask = tx_mask | (4'b0001 << stat_rx_active);

    logic        clk;
    logic        rst;
    logic [15:0] prescale;
    logic [3:0]  status;
    logic [7:0]  utx_tdata;
    logic        utx_tvalid;
    logic        utx_tlast;
    logic        utx_tready;
    logic [7:0]  urx_tdata;
    logic        urx_tvalid;
    logic        urx_tlast;
    logic        urx_tready;
    logic        txd;
    logic        rxd;
    logic        rxd_direct;
    logic        rxd_drv;

    int         vec_op [max_steps];
    int         vec_pre [max_steps];
    int         vec_byte [max_steps];
    int         vec_last [max_steps];
    int         vec_count [max_steps];
    int         vec_stat [max_steps];
    int         nvec = 0;
    int         errors = 0;
    int         checks = 0;
    int         cycle_count = 0;
    int         cycle_limit = 2000;
    integer     seed = 32'h45a9_60aa;
    logic [3:0] stat_seen;
    logic       bp_seen;
    logic [8:0] rx_q [$];

    assign rxd = rxd_direct ? rxd_drv : txd; // Loopback unless a step owns the line.

    tb_clock #(.period(8)) clock_i (.clk(clk));

    uart_stream #(.dw(8), .aw_tx(aw_tx), .aw_rx(aw_rx)) dut_i (
        .clk        (clk),
        .rst        (rst),
        .prescale   (prescale),
        .status     (status),
        .utx_tdata  (utx_tdata),
        .utx_tvalid (utx_tvalid),
        .utx_tlast  (utx_tlast),
        .utx_tready (utx_tready),
        .urx_tdata  (urx_tdata),
        .urx_tvalid (urx_tvalid),
        .urx_tlast  (urx_tlast),
        .urx_tready (urx_tready),
        .txd        (txd),
        .rxd        (rxd)
    );

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR: %s is 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic load_vectors();
        int    fd;
        int    n;
        int    op;
        int    pre;
        int    byt;
        int    lst;
        int    cnt;
        int    st;
        string line;
        fd = $fopen("uart_vectors.txt", "r");
        if (fd == 0) begin
            note_failure("Could not open uart_vectors.txt for reading.");
            return;
        end
        while (!$feof(fd) && nvec < max_steps) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h", op, pre, byt, lst, cnt, st);
                if (n == 6) begin
                    vec_op[nvec] = op;
                    vec_pre[nvec] = pre;
                    vec_byte[nvec] = byt;
                    vec_last[nvec] = lst;
                    vec_count[nvec] = cnt;
                    vec_stat[nvec] = st;
                    cycle_limit += cnt * 10 * pre * 8; // Ten bits per frame, eight clocks per step.
                    nvec++;
                end
            end
        end
        $fclose(fd);
        if (nvec == 0) begin
            note_failure("No test steps were read from uart_vectors.txt.");
        end
    endtask

    task automatic advance();
        if (urx_tvalid && urx_tready) begin
            rx_q.push_back({urx_tlast, urx_tdata}); // Transfer happens on the coming edge.
        end
        stat_seen = stat_seen | status;
        @(posedge clk);
        #1;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) advance();
    endtask

    task automatic wait_clear(input logic [3:0] mask, input int limit);
        int cycles;
        cycles = 0;
        while ((status & mask) != 4'b0000 && cycles < limit) begin
            advance();
            cycles++;
        end
        if ((status & mask) != 4'b0000) begin
            note_failure($sformatf("Status bits 0x%0h stayed set until the step timed out.",
                                   status & mask));
        end
    endtask

    task automatic stream_bytes(input int n_send, input logic [7:0] first, input logic last,
                                input int ready_mode, input int n_recv, input int limit);
        int         sent;
        int         recv;
        int         cycles;
        logic       tx_fire;
        logic [7:0] exp_b;
        logic [8:0] got;
        sent = 0;
        recv = 0;
        cycles = 0;
        while ((sent < n_send || recv < n_recv) && cycles < limit) begin
            utx_tvalid = (sent < n_send);
            utx_tdata = first + 8'(sent);
            utx_tlast = last;
            if (ready_mode == ready_random) begin
                urx_tready = 1'($random(seed));
            end else begin
                urx_tready = (ready_mode == ready_high);
            end
            tx_fire = utx_tvalid && utx_tready;
            if (utx_tvalid && !utx_tready) begin
                bp_seen = 1'b1;
            end
            advance();
            cycles++;
            if (tx_fire) begin
                sent++;
            end
            while (rx_q.size() > 0 && recv < n_recv) begin
                got = rx_q.pop_front();
                exp_b = first + 8'(recv);
                check("urx_tdata", got[7:0], exp_b);
                check("urx_tlast", got[8], 1);
                recv++;
            end
        end
        utx_tvalid = 1'b0;
        if (sent < n_send) begin
            note_failure($sformatf("Only %0d of %0d bytes were accepted on utx.", sent, n_send));
        end
        if (recv < n_recv) begin
            note_failure($sformatf("No byte received before timeout, %0d of %0d arrived on urx.",
                                   recv, n_recv));
        end
    endtask

    task automatic drive_frame(input logic [7:0] value, input logic stop_bit, input int p);
        logic [9:0] bits;
        bits = {stop_bit, value, 1'b0}; // Start bit goes out first, then the LSB.
        rxd_drv = 1'b1;
        rxd_direct = 1'b1;
        for (int b = 0; b < 10; b++) begin
            rxd_drv = bits[b];
            wait_cycles(8 * p);
        end
        rxd_drv = 1'b1;
        rxd_direct = 1'b0;
    endtask

    task automatic run_step(input int i);
        int         p;
        int         lim;
        int         keep;
        logic [7:0] b;
        p = vec_pre[i];
        b = 8'(vec_byte[i]);
        lim = (vec_count[i] + 2) * 80 * p + 200;
        keep = (vec_count[i] < rx_keep) ? vec_count[i] : rx_keep;
        prescale = 16'(p);
        stat_seen = 4'b0000;
        bp_seen = 1'b0;
        urx_tready = 1'b1;
        case (vec_op[i])
            0: begin
                check("txd", txd, 1);
                check("urx_tvalid", urx_tvalid, 0);
                check("utx_tready", utx_tready, 1);
            end
            1, 2: begin
                stream_bytes(vec_count[i], b, 1'(vec_last[i]),
                             (vec_op[i] == 2) ? ready_random : ready_high, vec_count[i], lim);
                urx_tready = 1'b1;
                wait_clear(busy_mask, lim);
                check("status[2] during stream", stat_seen[stat_overrun], 0);
                check("status activity seen", stat_seen & busy_mask, busy_mask);
                check("utx_tready stall seen", bp_seen, vec_count[i] > tx_keep);
            end
            3: begin
                stream_bytes(vec_count[i], b, 1'(vec_last[i]), ready_low, 0, lim);
                wait_clear(tx_mask, lim);
                wait_cycles(16 * p); // Let the last frame settle in the receiver.
                check("status[2]", status[stat_overrun], vec_count[i] > rx_keep);
                stream_bytes(0, b, 1'b0, ready_high, keep, lim);
                wait_clear(busy_mask, lim);
            end
            4, 5: begin
                drive_frame(b, vec_op[i] == 5, p);
                if (vec_op[i] == 5) begin
                    stream_bytes(0, b, 1'b0, ready_high, 1, lim);
                end
                wait_clear(busy_mask, lim);
            end
            default: note_failure($sformatf("Step %0d has an unknown opcode %0d.", i, vec_op[i]));
        endcase
        wait_cycles(16 * p);
        if (rx_q.size() != 0) begin
            note_failure($sformatf("%0d unexpected bytes appeared on urx.", rx_q.size()));
            rx_q.delete();
        end
        check("status", status, vec_stat[i]);
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= cycle_limit) begin
                $display("The run hit its limit of %0d cycles before all steps finished.",
                         cycle_limit);
                $display("Done: errors found");
                $finish;
            end
        end
    end

    initial begin
        int err_before;
        rst = 1'b1;
        prescale = 16'd1;
        utx_tdata = 8'h00;
        utx_tvalid = 1'b0;
        utx_tlast = 1'b0;
        urx_tready = 1'b1;
        rxd_direct = 1'b0;
        rxd_drv = 1'b1;
        load_vectors();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < nvec; i++) begin
            err_before = errors;
            run_step(i);
            $display("Step %0d (op %0d, prescale %0d): %s", i, vec_op[i], vec_pre[i],
                     (errors == err_before) ? "passed" : "failed");
        end
        $display("Steps run: %0d, checks: %0d, errors: %0d", nvec, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- uart_vectors.txt
# Columns, all hex: opcode prescale byte tlast count expected_status
# Opcodes: 0 reset state, 1 loopback, 2 burst with random urx_tready, 3 overrun,
#          4 frame with a bad stop bit on rxd, 5 good frame on rxd
0 0001 00 0 0 0
1 0001 a5 1 1 0
1 0002 3c 0 1 0
1 0001 00 1 1 0
1 0002 ff 1 1 0
1 0001 81 0 2 0
2 0001 10 0 8 0
2 0002 fc 1 6 0
2 0001 c0 0 10 0
3 0001 40 1 6 0
1 0001 5e 1 1 0
4 0002 5a 0 1 8
5 0002 96 0 1 0
4 0001 e1 0 1 8
1 0001 77 1 1 0
3 0002 a0 0 6 0

//--- build.f
uart_pkg.sv
stream_if.sv
stream_fifo.sv
uart_tx.sv
uart_rx.sv
uart_status.sv
uart_stream.sv
tb_clock.sv
uart_stream_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/1ns \
    --top-module uart_stream_tb -f build.f -o uart_sim

out=$(./obj_dir/uart_sim)
echo "$out"

if echo "$out" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1
